/* rtl/icache_config.svh */
// ====================
// cache geometry; ICACHE_BYTES must equal 8 * BANK_DEPTH
// FILL_WORDS should be a power of two, the fill counter wraps at it
// ====================
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// total cache storage in bytes
`define ICACHE_BYTES 4096

// entries per 32-bit RAM bank
// four banks of this depth cover the cache twice over (two read pairs)
`define BANK_DEPTH 512

// 32-bit words loaded by one fill request
`define FILL_WORDS 16

`endif

/* rtl/icachePkg.sv */
// ====================
// cache address and data types; only address bits 11:0 reach storage
// ====================
package icachePkg;

	// byte address as seen by fill and fetch
	// upper bits pass through untouched, the cache is directly addressed
	typedef logic [31:0] cacheAdr;

	// one word as delivered by the outside memory
	typedef logic [31:0] cacheWord;

	// eight bytes starting at the addressed byte
	// lowest address sits in bits 7:0
	typedef logic [63:0] insnWindow;

	// byte position inside a doubleword
	typedef logic [2:0] byteOff;

endpackage

/* rtl/insnPkg.sv */
// ====================
// instruction opcode and length types, shared by fetch and the model
// ====================
package insnPkg;

	// the first byte of every instruction
	typedef logic [7:0] opcodeT;

	// instruction length in bytes, 1 to 8
	typedef logic [3:0] insnLenT;

	// length rule of this instruction set
	// the low three opcode bits hold the length minus one
	function automatic insnLenT insnLength(opcodeT op);
		insnLenT len;
		len = insnLenT'(op[2:0]) + insnLenT'(1);
		return len;
	endfunction

endpackage

/* rtl/ramBank512x32.sv */
// ====================
// single-clock RAM, read data is registered and shows old data on collision
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module ramBank512x32 (
	input  logic                rclk,
	input  logic                we,
	input  logic [8:0]          wadr,
	input  icachePkg::cacheWord wdat,
	input  logic [8:0]          radr,
	output icachePkg::cacheWord rdat
);
	import icachePkg::*;

	// storage, no reset on purpose of being inferred as block RAM
	cacheWord mem [`BANK_DEPTH];

	// write and read share the one clock
	// a same-edge read of the written entry returns the previous contents
	always_ff @(posedge rclk) begin
		if (we) begin
			mem[wadr] <= wdat;
		end
		rdat <= mem[radr];
	end

	// both addresses come from reset registers in the fill and fetch units
	// the first edge is where their reset lands, so checking starts one edge later
	adrKnown: assert property (@(posedge rclk) 1'b1 |=> !$isunknown({wadr, radr}))
		else $error("bank address holds X");

endmodule

/* rtl/icacheMem4k.sv */
// ====================
// 4 KB cache, word writes, 64-bit window read at any byte one clock after pc
// reads wrap within 4 KB, so a window at 4092 takes its tail from address 0
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module icacheMem4k (
	input  logic                 rclk,
	input  logic                 wr,
	input  icachePkg::cacheAdr   wrAdr,
	input  icachePkg::cacheWord  wrDat,
	input  icachePkg::cacheAdr   pc,
	output icachePkg::insnWindow insn
);
	import icachePkg::*;

	// top index bit of the storage, bit 11 for 4 KB
	localparam int IdxHi = $clog2(`ICACHE_BYTES) - 1;

	cacheAdr     pcNext;
	byteOff      rOff;
	logic [1:0]  wrHalf;
	logic [8:0]  rdAdr [2];
	cacheWord    rdWord [4];
	logic [63:0] dw0;
	logic [63:0] dw1;

	// ====================
	// write side
	// ====================

	// bit 2 picks the low or high half of a doubleword
	// both read pairs take every write so that each holds the full image
	assign wrHalf = {wr & wrAdr[2], wr & ~wrAdr[2]};

	// ====================
	// read side
	// ====================

	// pair 0 reads the doubleword at pc, pair 1 the one after it
	assign pcNext = pc + 32'd8;
	assign rdAdr[0] = pc[IdxHi:3];
	assign rdAdr[1] = pcNext[IdxHi:3];

	// bank b serves half b%2 of read pair b/2
	for (genvar b = 0; b < 4; b++) begin : gBank
		ramBank512x32 uBank (
			.rclk (rclk),
			.we   (wrHalf[b % 2]),
			.wadr (wrAdr[IdxHi:3]),
			.wdat (wrDat),
			.radr (rdAdr[b / 2]),
			.rdat (rdWord[b])
		);
	end

	// the byte offset has to line up with the registered bank outputs
	always_ff @(posedge rclk) begin
		rOff <= pc[2:0];
	end

	assign dw0 = {rdWord[1], rdWord[0]};
	assign dw1 = {rdWord[3], rdWord[2]};

	// shifting the 16-byte pair right by the offset leaves the window in the low 8 bytes
	// offsets 1 to 7 pull the upper bytes from the following doubleword
	assign insn = insnWindow'({dw1, dw0} >> {rOff, 3'b000});

endmodule

/* rtl/icacheFill.sv */
// ====================
// fills FILL_WORDS words from fillAdr, which must be word aligned
// fillStart while busy is ignored; memAck beyond the last word is dropped
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module icacheFill (
	input  logic                rclk,
	input  logic                rst,
	input  logic                fillStart,
	input  icachePkg::cacheAdr  fillAdr,
	input  logic                memAck,
	input  icachePkg::cacheWord memData,
	output logic                fillBusy,
	output logic                fillDone,
	output logic                wr,
	output icachePkg::cacheAdr  wrAdr,
	output icachePkg::cacheWord wrDat
);
	localparam int CntW = $clog2(`FILL_WORDS);

	logic [CntW-1:0] wordCnt;
	logic            allAcked;
	logic            accept;
	logic            lastAck;
	logic            wrLast;

	// a word is taken while busy, until the whole block has been acknowledged
	assign accept = fillBusy & memAck & ~allAcked;
	assign lastAck = (wordCnt == CntW'(`FILL_WORDS - 1));

	always_ff @(posedge rclk) begin
		if (rst) begin
			fillBusy <= 1'b0;
			fillDone <= 1'b0;
			wr <= 1'b0;
			wrLast <= 1'b0;
			allAcked <= 1'b0;
			wordCnt <= '0;
			wrAdr <= '0;
		end else begin
			fillDone <= 1'b0;
			// the accepted word is written on the following edge
			wr <= accept;
			wrLast <= accept & lastAck;
			if (accept) begin
				wordCnt <= wordCnt + 1'b1;
			end
			if (accept && lastAck) begin
				allAcked <= 1'b1;
			end
			// the write address steps after each word lands
			if (wr) begin
				wrAdr <= wrAdr + 32'd4;
			end
			if (!fillBusy && fillStart) begin
				fillBusy <= 1'b1;
				wrAdr <= fillAdr;
				wordCnt <= '0;
			end
			// busy drops with the last write, done follows one cycle after it
			if (wrLast) begin
				fillBusy <= 1'b0;
				fillDone <= 1'b1;
				allAcked <= 1'b0;
			end
		end
	end

	// data is payload only, qualified by wr
	always_ff @(posedge rclk) begin
		if (accept) begin
			wrDat <= memData;
		end
	end

	// a misaligned base would split words across the bank halves
	wrAligned: assert property (@(posedge rclk) disable iff (rst) wr |-> wrAdr[1:0] == 2'b00)
		else $error("fill write address not word aligned");

	// the fetch unit relies on fillBusy covering every write
	wrInBusy: assert property (@(posedge rclk) disable iff (rst) wr |-> fillBusy)
		else $error("cache write outside a fill");

endmodule

/* rtl/insnFetch.sv */
// ====================
// steps through cached code, one instruction every two cycles while run is high
// no back-pressure, every insnValid must be taken; no fetch during a fill
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module insnFetch (
	input  logic                 rclk,
	input  logic                 rst,
	input  logic                 fetchStart,
	input  icachePkg::cacheAdr   startPc,
	input  logic                 run,
	input  logic                 fillBusy,
	output icachePkg::cacheAdr   pc,
	input  icachePkg::insnWindow insn,
	output logic                 insnValid,
	output icachePkg::cacheAdr   insnPc,
	output icachePkg::insnWindow insnOut,
	output insnPkg::insnLenT     insnLen
);
	import icachePkg::*;
	import insnPkg::*;

	// pc advances within the cache span, upper bits are kept
	localparam int OffW = $clog2(`ICACHE_BYTES);

	// issue presents pc to the memory, decode sees the returned window
	typedef enum logic {sIssue, sDecode} stepT;

	stepT    state;
	logic    active;
	cacheAdr pcStep;

	// ====================
	// decode
	// ====================

	// pc is held through decode, so it still names the reported instruction
	assign insnValid = active && (state == sDecode);
	assign insnPc = pc;
	assign insnOut = insn;
	assign insnLen = insnLength(opcodeT'(insn[7:0]));

	// next instruction address, wrapping past the last cache byte
	assign pcStep = {pc[31:OffW], pc[OffW-1:0] + OffW'(insnLen)};

	// ====================
	// stepper
	// ====================

	always_ff @(posedge rclk) begin
		if (rst) begin
			active <= 1'b0;
			state <= sIssue;
			pc <= '0;
		end else if (fetchStart) begin
			// a start always yields one instruction, run decides on the rest
			active <= 1'b1;
			state <= sIssue;
			pc <= startPc;
		end else if (active) begin
			if (state == sIssue) begin
				state <= sDecode;
			end else begin
				// run is looked at only here, so an issued read is always reported
				pc <= pcStep;
				state <= sIssue;
				active <= run;
			end
		end
	end

	// the window would mix old and new words if a fill were in progress
	noReadInFill: assert property (@(posedge rclk) disable iff (rst)
		(active && state == sIssue) |-> !fillBusy)
		else $error("instruction read issued during a cache fill");

endmodule

/* rtl/icacheTop.sv */
// ====================
// instruction cache data path top; the outside decides when to fill
// ====================
`timescale 1ns/1ps

module icacheTop (
	input  logic                 rclk,
	input  logic                 rst,
	// fill request and outside memory
	input  logic                 fillStart,
	input  icachePkg::cacheAdr   fillAdr,
	input  logic                 memAck,
	input  icachePkg::cacheWord  memData,
	output logic                 fillBusy,
	output logic                 fillDone,
	// fetch control and results
	input  logic                 fetchStart,
	input  icachePkg::cacheAdr   startPc,
	input  logic                 run,
	output logic                 insnValid,
	output icachePkg::cacheAdr   insnPc,
	output icachePkg::insnWindow insnOut,
	output insnPkg::insnLenT     insnLen
);
	import icachePkg::*;

	// write port from the fill engine
	logic      wr;
	cacheAdr   wrAdr;
	cacheWord  wrDat;

	// read port from the fetch unit
	cacheAdr   pc;
	insnWindow insn;

	icacheFill uFill (
		.rclk      (rclk),
		.rst       (rst),
		.fillStart (fillStart),
		.fillAdr   (fillAdr),
		.memAck    (memAck),
		.memData   (memData),
		.fillBusy  (fillBusy),
		.fillDone  (fillDone),
		.wr        (wr),
		.wrAdr     (wrAdr),
		.wrDat     (wrDat)
	);

	icacheMem4k uMem (
		.rclk  (rclk),
		.wr    (wr),
		.wrAdr (wrAdr),
		.wrDat (wrDat),
		.pc    (pc),
		.insn  (insn)
	);

	// fillBusy also goes to the fetch unit for its read check
	insnFetch uFetch (
		.rclk       (rclk),
		.rst        (rst),
		.fetchStart (fetchStart),
		.startPc    (startPc),
		.run        (run),
		.fillBusy   (fillBusy),
		.pc         (pc),
		.insn       (insn),
		.insnValid  (insnValid),
		.insnPc     (insnPc),
		.insnOut    (insnOut),
		.insnLen    (insnLen)
	);

endmodule

/* tb/icacheChecker.sv */
// ====================
// byte model of the cache and the comparisons; fetches must stay in filled space
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module icacheChecker (
	input logic                 rclk,
	input logic                 rst,
	input logic                 fillStart,
	input icachePkg::cacheAdr   fillAdr,
	input logic                 memAck,
	input icachePkg::cacheWord  memData,
	input logic                 fillBusy,
	input logic                 fillDone,
	input logic                 fetchStart,
	input icachePkg::cacheAdr   startPc,
	input logic                 run,
	input logic                 insnValid,
	input icachePkg::cacheAdr   insnPc,
	input icachePkg::insnWindow insnOut,
	input insnPkg::insnLenT     insnLen
);
	import icachePkg::*;

	// cache image as the observed fill traffic should have left it
	logic [7:0] cacheModel [`ICACHE_BYTES];

	// totals, the testbench top reads them for its closing line
	int    testsRun = 0;
	int    checkTotal = 0;
	int    errTotal = 0;
	string curName = "none";
	int    testChecks = 0;
	int    testErrs = 0;

	// fill side of the model
	logic        modelBusy = 1'b0;
	logic        awaitDone = 1'b0;
	logic [11:0] fillBase = '0;
	int          ackCnt = 0;

	// fetch side, fetchLive says another insnValid is still owed
	logic    fetchLive = 1'b0;
	cacheAdr expPc = '0;
	int      cyc = 0;
	int      lastCyc = 0;

	// ====================
	// bookkeeping
	// ====================

	task automatic startTest(input string name);
		curName = name;
		testChecks = 0;
		testErrs = 0;
	endtask

	task automatic closeTest();
		testsRun++;
		$display("test %s: %0d checks, %0d errors", curName, testChecks, testErrs);
	endtask

	task automatic compareValue(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		testChecks++;
		checkTotal++;
		if (act !== exp) begin
			testErrs++;
			errTotal++;
			$display("FAILED %s: %s expected %h actual %h", curName, what, exp, act);
		end
	endtask

	task automatic checkCondition(input logic ok, input string msg);
		testChecks++;
		checkTotal++;
		if (ok !== 1'b1) begin
			testErrs++;
			errTotal++;
			$display("ERROR in %s: %s", curName, msg);
		end
	endtask

	// eight model bytes from adr upward, wrapping past the last cache byte
	function automatic insnWindow modelWindow(input cacheAdr adr);
		insnWindow w;
		int i;
		int idx;
		for (i = 0; i < 8; i++) begin
			idx = (int'(adr[11:0]) + i) % `ICACHE_BYTES;
			w[8*i +: 8] = cacheModel[idx];
		end
		return w;
	endfunction

	// called once reset is released
	task automatic checkReset();
		compareValue("fillBusy", 64'd0, 64'(fillBusy));
		compareValue("fillDone", 64'd0, 64'(fillDone));
		compareValue("insnValid", 64'd0, 64'(insnValid));
	endtask

	// ====================
	// monitor
	// ====================

	// everything is sampled on the rising edge, inputs change on the falling one
	always @(posedge rclk) begin
		int         b;
		int         idx;
		logic [7:0] opByte;
		logic [3:0] expLen;
		cyc++;
		if (rst) begin
			modelBusy = 1'b0;
			awaitDone = 1'b0;
			fetchLive = 1'b0;
		end else begin
			// exactly one done is owed per block of acknowledged words
			if (fillDone === 1'b1) begin
				checkCondition(awaitDone, "fillDone without a completed block of words");
				awaitDone = 1'b0;
			end
			if (fillStart === 1'b1 && !modelBusy) begin
				checkCondition(!awaitDone, "previous fill ended without fillDone");
				modelBusy = 1'b1;
				fillBase = fillAdr[11:0];
				ackCnt = 0;
			end else if (memAck === 1'b1 && modelBusy) begin
				checkCondition(fillBusy, "memAck taken while the fill engine was idle");
				// words land in ascending order, lowest address in the low byte
				for (b = 0; b < 4; b++) begin
					idx = (int'(fillBase) + 4 * ackCnt + b) % `ICACHE_BYTES;
					cacheModel[idx] = memData[8*b +: 8];
				end
				ackCnt++;
				if (ackCnt == `FILL_WORDS) begin
					modelBusy = 1'b0;
					awaitDone = 1'b1;
				end
			end

			if (fetchStart === 1'b1) begin
				fetchLive = 1'b1;
				expPc = startPc;
				lastCyc = cyc;
			end else if (insnValid === 1'b1) begin
				checkCondition(fetchLive, "insnValid arrived after run was dropped");
				compareValue("cycles since previous step", 64'd2, 64'(cyc - lastCyc));
				// length is the low three opcode bits plus one
				opByte = cacheModel[int'(expPc[11:0])];
				expLen = {1'b0, opByte[2:0]} + 4'd1;
				compareValue("insnPc", 64'(expPc), 64'(insnPc));
				compareValue("insnOut", modelWindow(expPc), insnOut);
				compareValue("insnLen", 64'(expLen), 64'(insnLen));
				expPc = {expPc[31:12], expPc[11:0] + {8'd0, expLen}};
				lastCyc = cyc;
				// run at the reporting edge decides whether another one follows
				fetchLive = run;
			end else if (fetchLive && (cyc - lastCyc > 2)) begin
				checkCondition(1'b0, "insnValid missing while stepping");
				fetchLive = 1'b0;
			end
		end
	end

endmodule

/* tb/icacheTb.sv */
// ====================
// fills the whole cache with random words, then single fetches, stepping and stops
// ====================
`timescale 1ns/1ps
`include "icache_config.svh"

module icacheTb;
	import icachePkg::*;

	localparam logic [31:0] Seed = 32'hb484_2ee5;

	// the watchdog limit is worked out from these test lengths
	localparam int NumFills = `ICACHE_BYTES / (4 * `FILL_WORDS);
	localparam int MaxGap = 3;
	localparam int NumAligned = 16;
	localparam int NumUnaligned = 48;
	localparam int StepCount = 300;
	localparam int NumStops = 6;
	localparam int MaxStopSteps = 20;
	localparam int FillCycles = NumFills * (`FILL_WORDS * (MaxGap + 1) + 6);
	localparam int FetchCycles = (NumAligned + NumUnaligned + 2) * 4 + StepCount * 2 + 10
		+ NumStops * (MaxStopSteps * 2 + 12);
	localparam int LimitCycles = 2 * (FillCycles + FetchCycles) + 50;

	logic      rclk;
	logic      rst;
	logic      fillStart;
	cacheAdr   fillAdr;
	logic      memAck;
	cacheWord  memData;
	logic      fillBusy;
	logic      fillDone;
	logic      fetchStart;
	cacheAdr   startPc;
	logic      run;
	logic      insnValid;
	cacheAdr   insnPc;
	insnWindow insnOut;
	insnPkg::insnLenT insnLen;

	icacheTop u_icacheTop (
		.rclk       (rclk),
		.rst        (rst),
		.fillStart  (fillStart),
		.fillAdr    (fillAdr),
		.memAck     (memAck),
		.memData    (memData),
		.fillBusy   (fillBusy),
		.fillDone   (fillDone),
		.fetchStart (fetchStart),
		.startPc    (startPc),
		.run        (run),
		.insnValid  (insnValid),
		.insnPc     (insnPc),
		.insnOut    (insnOut),
		.insnLen    (insnLen)
	);

	icacheChecker modelCheck (
		.rclk       (rclk),
		.rst        (rst),
		.fillStart  (fillStart),
		.fillAdr    (fillAdr),
		.memAck     (memAck),
		.memData    (memData),
		.fillBusy   (fillBusy),
		.fillDone   (fillDone),
		.fetchStart (fetchStart),
		.startPc    (startPc),
		.run        (run),
		.insnValid  (insnValid),
		.insnPc     (insnPc),
		.insnOut    (insnOut),
		.insnLen    (insnLen)
	);

	// 100 ns period
	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	// ====================
	// stimulus tasks
	// ====================

	// one block of words with random idle cycles before each acknowledge
	task automatic fillBlock(input cacheAdr base);
		int gap;
		int w;
		@(negedge rclk);
		fillStart = 1'b1;
		fillAdr = base;
		@(negedge rclk);
		fillStart = 1'b0;
		for (w = 0; w < `FILL_WORDS; w++) begin
			gap = int'($urandom_range(MaxGap, 0));
			repeat (gap) @(negedge rclk);
			memAck = 1'b1;
			memData = $urandom;
			@(negedge rclk);
			memAck = 1'b0;
		end
		while (fillDone !== 1'b1) begin
			@(negedge rclk);
		end
		// the checker samples the done pulse on the next rising edge
		@(negedge rclk);
	endtask

	// run stays low, so the start yields a single instruction
	task automatic fetchOnce(input cacheAdr pc);
		@(negedge rclk);
		fetchStart = 1'b1;
		startPc = pc;
		run = 1'b0;
		@(negedge rclk);
		fetchStart = 1'b0;
		while (insnValid !== 1'b1) begin
			@(negedge rclk);
		end
		// the reported instruction is compared on the next rising edge
		@(negedge rclk);
	endtask

	// lag 1 drops run in an issue cycle, so one more step is still reported
	task automatic stepRun(input cacheAdr pc, input int steps, input int lag);
		int seen;
		seen = 0;
		@(negedge rclk);
		fetchStart = 1'b1;
		startPc = pc;
		run = 1'b1;
		while (seen < steps) begin
			@(negedge rclk);
			fetchStart = 1'b0;
			if (insnValid === 1'b1) begin
				seen++;
			end
		end
		repeat (lag) @(negedge rclk);
		run = 1'b0;
		repeat (8) @(negedge rclk);
	endtask

	// ====================
	// test sequence
	// ====================

	initial begin
		int i;
		int n;
		void'($urandom(Seed));
		rst = 1'b1;
		fillStart = 1'b0;
		fillAdr = '0;
		memAck = 1'b0;
		memData = '0;
		fetchStart = 1'b0;
		startPc = '0;
		run = 1'b0;
		repeat (5) @(posedge rclk);
		@(negedge rclk);
		rst = 1'b0;

		modelCheck.startTest("reset");
		@(negedge rclk);
		modelCheck.checkReset();
		modelCheck.closeTest();

		// every byte gets written, so no fetch below can see unknown data
		modelCheck.startTest("fill");
		for (i = 0; i < NumFills; i++) begin
			fillBlock(32'(i * 4 * `FILL_WORDS));
		end
		modelCheck.closeTest();

		modelCheck.startTest("aligned");
		for (i = 0; i < NumAligned; i++) begin
			fetchOnce($urandom & 32'h0000_0ff8);
		end
		modelCheck.closeTest();

		// offsets cycle through 0 to 7 and the last two windows wrap past 4095
		modelCheck.startTest("unaligned");
		for (i = 0; i < NumUnaligned; i++) begin
			fetchOnce(($urandom & 32'h0000_0ff8) | 32'(i % 8));
		end
		fetchOnce(32'd4093);
		fetchOnce(32'd4095);
		modelCheck.closeTest();

		// starts near the top so the program counter wraps to address 0
		modelCheck.startTest("stepping");
		stepRun(32'd4056 + ($urandom & 32'd7), StepCount, 0);
		modelCheck.closeTest();

		modelCheck.startTest("stop");
		for (i = 0; i < NumStops; i++) begin
			n = int'($urandom_range(MaxStopSteps, 3));
			stepRun($urandom & 32'h0000_0fff, n, i % 2);
		end
		modelCheck.closeTest();

		$display("tests %0d, checks %0d, errors %0d",
			modelCheck.testsRun, modelCheck.checkTotal, modelCheck.errTotal);
		if (modelCheck.errTotal == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// a fill or fetch that never completes ends the run here
	initial begin
		repeat (LimitCycles) @(posedge rclk);
		$display("watchdog: run still going after %0d cycles, a fill or fetch hung",
			LimitCycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* icacheTop.f */
+incdir+rtl
rtl/icachePkg.sv
rtl/insnPkg.sv
rtl/ramBank512x32.sv
rtl/icacheMem4k.sv
rtl/icacheFill.sv
rtl/insnFetch.sv
rtl/icacheTop.sv
tb/icacheChecker.sv
tb/icacheTb.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench
# any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= icacheTb
FILELIST  ?= icacheTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
